// File: source/ucpu_pkg.sv
// microcoded cpu shared definitions
// widths, bus codes, microinstruction layout

package ucpu_pkg;

    localparam int data_w = 16;  // bus and register width
    localparam int addr_w = 8;   // ram address width
    localparam int byte_w = 8;   // ir half width
    localparam int sel_w  = 3;   // out-field and in-field width

    // out-field codes, only decoded in move mode
    localparam logic [sel_w-1:0] src_pc  = 3'd0;
    localparam logic [sel_w-1:0] src_irh = 3'd1;  // ir high byte, zero extended
    localparam logic [sel_w-1:0] src_irl = 3'd2;  // ir low byte, zero extended
    localparam logic [sel_w-1:0] src_mem = 3'd3;
    // 4 and 5 would be x and y out, left spare
    localparam logic [sel_w-1:0] src_dev = 3'd6;  // external device input
    // 7 spare

    // in-field codes, decoded in both modes
    localparam logic [sel_w-1:0] dst_none = 3'd0;  // nobody listens
    localparam logic [sel_w-1:0] dst_ar   = 3'd1;
    localparam logic [sel_w-1:0] dst_ir   = 3'd2;
    localparam logic [sel_w-1:0] dst_mem  = 3'd3;  // ram at ar
    localparam logic [sel_w-1:0] dst_x    = 3'd4;
    localparam logic [sel_w-1:0] dst_y    = 3'd5;
    localparam logic [sel_w-1:0] dst_dev  = 3'd6;  // device output latch

    // alu control, msb first as in uinstr[14:9]
    typedef struct packed {
        logic ex;  // x enable, else zero
        logic nx;  // invert x
        logic ey;  // y enable, else zero
        logic ny;  // invert y
        logic f;   // add, else and
        logic no;  // invert result
    } alu_flags_t;

    // eo_n low: alu drives the bus
    typedef struct packed {
        logic             eo_n;       // [15]
        alu_flags_t       flags;      // [14:9]
        logic [sel_w-1:0] dst;        // [8:6]
        logic             jc;         // [5]
        logic             jz;         // [4]
        logic             jgt;        // [3]
        logic             jlt;        // [2]
        logic [1:0]       spare;      // [1:0]
    } alu_view_t;

    // eo_n high: a register or device drives the bus
    typedef struct packed {
        logic             eo_n;       // [15]
        logic [sel_w-1:0] src;        // [14:12]
        logic             rt;         // [11] microstep reset
        logic             pp;         // [10] pc increment
        logic             spare9;     // [9]
        logic [sel_w-1:0] dst;        // [8:6] same as alu view from here down
        logic             jc;
        logic             jz;
        logic             jgt;
        logic             jlt;
        logic [1:0]       spare;
    } move_view_t;

    typedef union packed {
        alu_view_t  alu_view;
        move_view_t move_view;
    } uinstr_t;

endpackage

// File: source/control_decode.sv
// microinstruction decoder
`timescale 1ns/1ps

module control_decode (
    input  ucpu_pkg::uinstr_t    uinstr,
    output logic                 eo_n,   // alu onto bus
    output logic                 po_n,
    output logic                 ioh_n,
    output logic                 iol_n,
    output logic                 mo_n,
    output logic                 do_n,
    output logic                 ai_n,
    output logic                 ii_n,
    output logic                 xi_n,
    output logic                 yi_n,
    output logic                 mi,     // ram write
    output logic                 di,     // device latch load
    output logic                 rt,
    output logic                 pp,
    output logic                 jc,
    output logic                 jz,
    output logic                 jgt,
    output logic                 jlt,
    output ucpu_pkg::alu_flags_t alu_flags
);
    import ucpu_pkg::*;

    logic                  move_mode;
    logic [2**sel_w-1:0]   out_dec;  // active low one-hot
    logic [2**sel_w-1:0]   in_dec;   // active low one-hot

    // 3-to-8 decoder with active low outputs, all high when disabled
    function automatic logic [2**sel_w-1:0] dec_n(input logic en, input logic [sel_w-1:0] sel);
        logic [2**sel_w-1:0] d;
        d = '1;
        if (en) begin
            d[sel] = 1'b0;
        end
        return d;
    endfunction

    assign eo_n      = uinstr.alu_view.eo_n;
    assign move_mode = uinstr.move_view.eo_n;  // high bit set selects move view

    // alu has no side effect unless eo_n is low, so pass flags unconditionally
    assign alu_flags = uinstr.alu_view.flags;

    assign out_dec = dec_n(move_mode, uinstr.move_view.src);
    assign in_dec  = dec_n(1'b1, uinstr.alu_view.dst);  // code 0 has no receiver

    // bus sources
    assign po_n  = out_dec[src_pc];
    assign ioh_n = out_dec[src_irh];
    assign iol_n = out_dec[src_irl];
    assign mo_n  = out_dec[src_mem];
    assign do_n  = out_dec[src_dev];

    // bus receivers
    assign ai_n = in_dec[dst_ar];
    assign ii_n = in_dec[dst_ir];
    assign xi_n = in_dec[dst_x];
    assign yi_n = in_dec[dst_y];
    assign mi   = ~in_dec[dst_mem];  // inverted to active high
    assign di   = ~in_dec[dst_dev];

    // bits 11 and 10 are alu flags in alu mode
    assign rt = move_mode & uinstr.move_view.rt;
    assign pp = move_mode & uinstr.move_view.pp;

    // jump bits sit at the same place in both views
    assign jc  = uinstr.alu_view.jc;
    assign jz  = uinstr.alu_view.jz;
    assign jgt = uinstr.alu_view.jgt;
    assign jlt = uinstr.alu_view.jlt;

endmodule

// File: source/alu.sv
// combinational alu
`timescale 1ns/1ps

module alu (
    input  logic [ucpu_pkg::data_w-1:0] x,
    input  logic [ucpu_pkg::data_w-1:0] y,
    input  ucpu_pkg::alu_flags_t        alu_flags,
    output logic [ucpu_pkg::data_w-1:0] result,
    output logic                        carry,
    output logic                        zero,
    output logic                        neg
);
    import ucpu_pkg::*;

    logic [data_w-1:0] xc;    // conditioned x
    logic [data_w-1:0] yc;    // conditioned y
    logic [data_w:0]   sum;   // extra bit is carry out
    logic [data_w-1:0] core;  // before output invert

    always_comb begin
        // zero or pass, then optional invert
        xc = alu_flags.ex ? x : '0;
        if (alu_flags.nx) begin
            xc = ~xc;
        end
        yc = alu_flags.ey ? y : '0;
        if (alu_flags.ny) begin
            yc = ~yc;
        end

        sum = {1'b0, xc} + {1'b0, yc};

        if (alu_flags.f) begin
            core  = sum[data_w-1:0];
            carry = sum[data_w];
        end else begin
            core  = xc & yc;
            carry = 1'b0;  // no carry out of and
        end

        result = alu_flags.no ? ~core : core;
    end

    // flags from the final value
    assign zero = (result == '0);
    assign neg  = result[data_w-1];  // sign bit

endmodule

// File: source/bus_arbiter.sv
// shared bus multiplexer
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                        po_n,
    input  logic                        ioh_n,
    input  logic                        iol_n,
    input  logic                        mo_n,
    input  logic                        do_n,
    input  logic                        eo_n,
    input  logic [ucpu_pkg::data_w-1:0] pc_q,
    input  logic [ucpu_pkg::data_w-1:0] ir_q,
    input  logic [ucpu_pkg::data_w-1:0] mem_q,
    input  logic [ucpu_pkg::data_w-1:0] dev_in,
    input  logic [ucpu_pkg::data_w-1:0] alu_q,
    output logic [ucpu_pkg::data_w-1:0] bus
);
    import ucpu_pkg::*;

    logic [data_w-1:0] ir_hi;
    logic [data_w-1:0] ir_lo;

    // each half of ir lands in the low byte
    assign ir_hi = {{(data_w-byte_w){1'b0}}, ir_q[data_w-1 -: byte_w]};
    assign ir_lo = {{(data_w-byte_w){1'b0}}, ir_q[byte_w-1:0]};

    // decoder guarantees a single source, order only matters for spare codes
    always_comb begin
        if (!eo_n) begin
            bus = alu_q;  // alu mode wins
        end else if (!po_n) begin
            bus = pc_q;
        end else if (!ioh_n) begin
            bus = ir_hi;
        end else if (!iol_n) begin
            bus = ir_lo;
        end else if (!mo_n) begin
            bus = mem_q;
        end else if (!do_n) begin
            bus = dev_in;
        end else begin
            bus = '0;  // idle or spare code
        end
    end

endmodule

// File: source/program_counter.sv
// program counter
`timescale 1ns/1ps

module program_counter (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        pp,     // increment
    input  logic                        jc,
    input  logic                        jz,
    input  logic                        jgt,
    input  logic                        jlt,
    input  logic                        carry,  // from this cycle's alu result
    input  logic                        zero,
    input  logic                        neg,
    input  logic [ucpu_pkg::data_w-1:0] ar_q,   // jump target
    output logic [ucpu_pkg::data_w-1:0] pc_q
);
    import ucpu_pkg::*;

    logic take_c;
    logic take_z;
    logic take_gt;
    logic take_lt;
    logic take_jump;

    // each enabled condition checked against the live flags
    assign take_c  = jc & carry;
    assign take_z  = jz & zero;
    assign take_gt = jgt & ~zero & ~neg;  // strictly positive
    assign take_lt = jlt & neg;

    assign take_jump = take_c | take_z | take_gt | take_lt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= '0;
        end else if (take_jump) begin
            pc_q <= ar_q;  // jump beats increment
        end else if (pp) begin
            pc_q <= pc_q + data_w'(1);
        end
    end

endmodule

// File: source/reg_file.sv
// bus loaded registers
// ir, x, y, ar and device output latch
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [ucpu_pkg::data_w-1:0] bus,
    input  logic                        ai_n,     // ar load
    input  logic                        ii_n,     // ir load
    input  logic                        xi_n,     // x load
    input  logic                        yi_n,     // y load
    input  logic                        di,       // device latch load, active high
    output logic [ucpu_pkg::data_w-1:0] ar_q,
    output logic [ucpu_pkg::data_w-1:0] ir_q,
    output logic [ucpu_pkg::data_w-1:0] x_q,
    output logic [ucpu_pkg::data_w-1:0] y_q,
    output logic [ucpu_pkg::data_w-1:0] dev_out
);

    // address register, also the jump target
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ar_q <= '0;
        end else if (!ai_n) begin
            ar_q <= bus;
        end
    end

    // instruction register, read back a byte at a time
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir_q <= '0;
        end else if (!ii_n) begin
            ir_q <= bus;
        end
    end

    // alu operands
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_q <= '0;
            y_q <= '0;
        end else begin
            if (!xi_n) begin
                x_q <= bus;
            end
            if (!yi_n) begin
                y_q <= bus;
            end
        end
    end

    // device output latch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dev_out <= '0;
        end else if (di) begin
            dev_out <= bus;
        end
    end

endmodule

// File: source/ram.sv
// 256x16 data memory
`timescale 1ns/1ps

module ram (
    input  logic                        clk,
    input  logic                        mi,     // write strobe
    input  logic [ucpu_pkg::addr_w-1:0] addr,   // low bits of ar
    input  logic [ucpu_pkg::data_w-1:0] bus,
    output logic [ucpu_pkg::data_w-1:0] mem_q
);
    import ucpu_pkg::*;

    logic [data_w-1:0] mem [2**addr_w];

    // write at the edge after the strobe
    always_ff @(posedge clk) begin
        if (mi) begin
            mem[addr] <= bus;
        end
    end

    // read is combinational so mo_n can put it on the bus same cycle
    assign mem_q = mem[addr];

endmodule

// File: source/ucpu_top.sv
// microcoded cpu datapath top
`timescale 1ns/1ps

module ucpu_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  ucpu_pkg::uinstr_t           uinstr,     // one per clock
    input  logic [ucpu_pkg::data_w-1:0] dev_in,
    output logic [ucpu_pkg::data_w-1:0] bus,
    output logic [ucpu_pkg::data_w-1:0] pc_q,
    output logic [ucpu_pkg::data_w-1:0] dev_out,
    output logic                        ustep_rst   // microstep reset
);
    import ucpu_pkg::*;

    // decoder strobes
    logic       eo_n, po_n, ioh_n, iol_n, mo_n, do_n;
    logic       ai_n, ii_n, xi_n, yi_n;
    logic       mi, di, pp;
    logic       jc, jz, jgt, jlt;
    alu_flags_t alu_flags;

    // datapath
    logic [data_w-1:0] alu_q;
    logic              carry, zero, neg;
    logic [data_w-1:0] ar_q, ir_q, x_q, y_q;
    logic [data_w-1:0] mem_q;

    control_decode u_decode (
        .uinstr(uinstr), .eo_n(eo_n),
        .po_n(po_n), .ioh_n(ioh_n), .iol_n(iol_n), .mo_n(mo_n), .do_n(do_n),
        .ai_n(ai_n), .ii_n(ii_n), .xi_n(xi_n), .yi_n(yi_n),
        .mi(mi), .di(di),
        .rt(ustep_rst),  // goes straight out to the sequencer
        .pp(pp),
        .jc(jc), .jz(jz), .jgt(jgt), .jlt(jlt),
        .alu_flags(alu_flags)
    );

    alu u_alu (
        .x(x_q), .y(y_q), .alu_flags(alu_flags),
        .result(alu_q), .carry(carry), .zero(zero), .neg(neg)
    );

    bus_arbiter u_arbiter (
        .po_n(po_n), .ioh_n(ioh_n), .iol_n(iol_n), .mo_n(mo_n), .do_n(do_n),
        .eo_n(eo_n),
        .pc_q(pc_q), .ir_q(ir_q), .mem_q(mem_q), .dev_in(dev_in), .alu_q(alu_q),
        .bus(bus)
    );

    program_counter u_pc (
        .clk(clk), .arst_n(arst_n), .pp(pp),
        .jc(jc), .jz(jz), .jgt(jgt), .jlt(jlt),
        .carry(carry), .zero(zero), .neg(neg),
        .ar_q(ar_q), .pc_q(pc_q)
    );

    reg_file u_regs (
        .clk(clk), .arst_n(arst_n), .bus(bus),
        .ai_n(ai_n), .ii_n(ii_n), .xi_n(xi_n), .yi_n(yi_n), .di(di),
        .ar_q(ar_q), .ir_q(ir_q), .x_q(x_q), .y_q(y_q), .dev_out(dev_out)
    );

    ram u_ram (
        .clk(clk), .mi(mi),
        .addr(ar_q[addr_w-1:0]),  // only low byte of ar reaches the ram
        .bus(bus), .mem_q(mem_q)
    );

endmodule

// File: tb/ucpu_checker.sv
// reference model and scoreboard
`timescale 1ns/1ps

module ucpu_checker (
    input  logic        clk,
    input  logic        arst_n,
    input  int          test_id,    // 0 while idle
    input  logic [15:0] uinstr,
    input  logic [15:0] dev_in,
    input  logic [15:0] bus,
    input  logic [15:0] pc_q,
    input  logic [15:0] dev_out,
    input  logic        ustep_rst,
    output logic        ready,      // reset release seen
    output logic        done,       // last test closed
    output int          n_tests,
    output int          n_failed,
    output int          n_errors
);
    import ucpu_pkg::*;

    logic [15:0] ar, ir, x, y, dev, pc;  // model registers
    logic [15:0] mem [256];
    logic [15:0] exp_bus;
    logic [15:0] res;
    logic        carry;
    logic        take;
    int          cur_id;
    int          test_errs;

    task automatic mismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
        $display("ERR test %0d %s: got %h expected %h", cur_id, name, got, exp);
        test_errs++;
        n_errors++;
    endtask

    // flags msb first: ex nx ey ny f no, carry in bit 16
    function automatic logic [16:0] alu_model(input logic [5:0] fl, input logic [15:0] a,
                                              input logic [15:0] b);
        logic [15:0] xa;
        logic [15:0] yb;
        logic [16:0] s;
        xa = fl[5] ? a : 16'h0;
        xa = fl[4] ? ~xa : xa;
        yb = fl[3] ? b : 16'h0;
        yb = fl[2] ? ~yb : yb;
        s  = fl[1] ? ({1'b0, xa} + {1'b0, yb}) : {1'b0, xa & yb};
        return fl[0] ? {s[16], ~s[15:0]} : s;
    endfunction

    always @(posedge clk) begin
        if (!arst_n) begin
            {ar, ir, x, y, dev, pc} = '0;
            {ready, done} = 2'b00;
            {n_tests, n_failed, n_errors, cur_id, test_errs} = '0;
        end else begin
            ready = 1'b1;
            // registers loaded at the previous edge
            if (pc_q !== pc)
                mismatch("pc_q", pc_q, pc);
            if (dev_out !== dev)
                mismatch("dev_out", dev_out, dev);
            if (test_id != cur_id) begin
                if (cur_id != 0) begin
                    n_tests++;
                    n_failed += (test_errs != 0);
                    $display("test %0d %s, %0d errors", cur_id,
                             (test_errs == 0) ? "ok" : "FAIL", test_errs);
                end
                done      = (test_id == 0) && (cur_id != 0);
                cur_id    = test_id;
                test_errs = 0;
            end
            {carry, res} = alu_model(uinstr[14:9], x, y);  // alu runs in both modes
            case (uinstr[14:12])
                src_pc:  exp_bus = pc;
                src_irh: exp_bus = {8'h00, ir[15:8]};
                src_irl: exp_bus = {8'h00, ir[7:0]};
                src_mem: exp_bus = mem[ar[7:0]];
                src_dev: exp_bus = dev_in;
                default: exp_bus = 16'h0;  // spare codes
            endcase
            if (!uinstr[15])
                exp_bus = res;
            if (bus !== exp_bus)
                mismatch("bus", bus, exp_bus);
            if (ustep_rst !== (uinstr[15] & uinstr[11]))
                mismatch("ustep_rst", {15'h0, ustep_rst}, {15'h0, uinstr[15] & uinstr[11]});
            // any enabled condition jumps to old ar, else pp in move mode
            take = (uinstr[5] & carry) | (uinstr[4] & (res == 16'h0))
                 | (uinstr[3] & (res != 16'h0) & !res[15]) | (uinstr[2] & res[15]);
            if (take)
                pc = ar;
            else if (uinstr[15] & uinstr[10])
                pc = pc + 16'h1;
            case (uinstr[8:6])
                dst_ar:  ar = exp_bus;
                dst_ir:  ir = exp_bus;
                dst_mem: mem[ar[7:0]] = exp_bus;
                dst_x:   x = exp_bus;
                dst_y:   y = exp_bus;
                dst_dev: dev = exp_bus;
                default: ;
            endcase
        end
    end

endmodule

// File: tb/tb_ucpu.sv
// microcoded cpu datapath testbench
`timescale 1ns/1ps

module tb_ucpu;
    import ucpu_pkg::*;

    localparam logic [15:0] idle_op = 16'hf000;  // spare source, no load
    // add, and, x-y, y-x, or, x+y+1 with mode 0 rightmost
    localparam logic [35:0] alu_modes = {6'b111111, 6'b111101, 6'b101111,
                                         6'b111011, 6'b101000, 6'b101010};
    // jump cases on x=ffff y=0001, true then false for jc jz jgt jlt
    localparam logic [47:0] jump_flags = {6'b101000, 6'b010010, 6'b000000, 6'b101000,
                                          6'b101000, 6'b000000, 6'b101000, 6'b101010};
    localparam logic [31:0] jump_sel = 32'h11224488;

    logic        clk;
    logic        arst_n;
    logic [15:0] uinstr, dev_in, bus, pc_q, dev_out;
    logic        ustep_rst, ready, done, timed_out;
    int          test_id, n_tests, n_failed, n_errors, cnt;
    int          ids[$];
    logic [15:0] codes[$];
    logic [15:0] devs[$];
    integer      seed;

    ucpu_top DUT (
        .clk(clk), .arst_n(arst_n), .uinstr(uinstr), .dev_in(dev_in),
        .bus(bus), .pc_q(pc_q), .dev_out(dev_out), .ustep_rst(ustep_rst)
    );

    ucpu_checker u_checker (
        .clk(clk), .arst_n(arst_n), .test_id(test_id), .uinstr(uinstr), .dev_in(dev_in),
        .bus(bus), .pc_q(pc_q), .dev_out(dev_out), .ustep_rst(ustep_rst),
        .ready(ready), .done(done),
        .n_tests(n_tests), .n_failed(n_failed), .n_errors(n_errors)
    );

    function automatic logic [15:0] rnd16();
        return 16'($random(seed));
    endfunction

    function automatic logic [15:0] move_op(input logic [2:0] src, input logic [2:0] dst,
                                            input logic rt, input logic pp, input logic [3:0] j);
        return {1'b1, src, rt, pp, 1'b0, dst, j, 2'b00};
    endfunction

    function automatic logic [15:0] alu_op(input logic [5:0] fl, input logic [2:0] dst,
                                           input logic [3:0] j);
        return {1'b0, fl, dst, j, 2'b00};
    endfunction

    task automatic add_step(input int id, input logic [15:0] code, input logic [15:0] dev);
        ids.push_back(id);
        codes.push_back(code);
        devs.push_back(dev);
    endtask

    // dev_in straight into a register
    task automatic load(input int id, input logic [2:0] dst, input logic [15:0] val);
        add_step(id, move_op(src_dev, dst, 1'b0, 1'b0, 4'h0), val);
    endtask

    task automatic build_table();
        logic [15:0] a;
        load(1, dst_x, rnd16());  // moves, then ir halves
        load(1, dst_y, rnd16());
        load(1, dst_ir, rnd16());
        load(1, dst_ar, rnd16());
        add_step(1, move_op(src_irh, dst_x, 1'b0, 1'b0, 4'h0), rnd16());
        add_step(1, move_op(src_irl, dst_dev, 1'b0, 1'b0, 4'h0), rnd16());
        for (int k = 0; k < 8; k++) begin
            a      = rnd16();
            a[7:0] = 8'(k % 4 * 85);  // 00 55 aa ff, upper byte ignored by ram
            load(2, dst_ar, a);
            if (k < 4)
                load(2, dst_mem, rnd16());
            else
                add_step(2, move_op(src_mem, dst_y, 1'b0, 1'b0, 4'h0), rnd16());
        end
        for (int p = 0; p < 2; p++) begin
            load(3, dst_x, rnd16());
            load(3, dst_y, rnd16());
            for (int k = 0; k < 6; k++)
                add_step(3, alu_op(alu_modes[k*6 +: 6], dst_dev, 4'h0), rnd16());
        end
        load(4, dst_x, 16'hffff);
        load(4, dst_y, 16'h0001);
        for (int k = 0; k < 8; k++) begin
            load(4, dst_ar, rnd16());  // new target per case
            add_step(4, alu_op(jump_flags[k*6 +: 6], dst_none, jump_sel[k*4 +: 4]), rnd16());
        end
        load(4, dst_ar, rnd16());
        add_step(4, move_op(3'd7, dst_none, 1'b0, 1'b1, 4'b0010), rnd16());  // jgt beats pp
        add_step(4, move_op(3'd7, dst_none, 1'b0, 1'b1, 4'b0001), rnd16());  // jlt fails
        for (int k = 0; k < 3; k++)
            add_step(5, move_op(src_pc, dst_none, 1'b0, 1'b1, 4'h0), rnd16());
        add_step(5, move_op(src_pc, dst_dev, 1'b1, 1'b0, 4'h0), rnd16());
        add_step(5, alu_op(6'b111111, dst_x, 4'h0), rnd16());  // bit 11 set, ustep_rst low
        load(5, dst_dev, rnd16());
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        seed      = 32'hc1625343;
        timed_out = 1'b0;
        arst_n    = 1'b0;
        test_id   = 0;
        uinstr    = idle_op;
        dev_in    = 16'h0;
        build_table();
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        cnt = 0;
        while (ready !== 1'b1 && cnt < 20) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (ready !== 1'b1) begin
            $display("timeout: checker never saw reset released");
            timed_out = 1'b1;
        end else begin
            foreach (ids[i]) begin
                @(posedge clk);
                #1;
                test_id = ids[i];
                uinstr  = codes[i];
                dev_in  = devs[i];
            end
            @(posedge clk);
            #1;
            test_id = 0;
            uinstr  = idle_op;
            cnt     = 0;
            while (done !== 1'b1 && cnt < 50) begin
                @(posedge clk);
                #1;
                cnt++;
            end
            if (done !== 1'b1) begin
                $display("timeout: checker did not close the last test");
                timed_out = 1'b1;
            end
        end
        $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, n_errors);
        if (timed_out || n_failed != 0 || n_errors != 0) begin
            $display("Test failures found");
        end else begin
            $display("All tests passed!");
        end
        $finish;
    end

endmodule

// File: filelist.f
source/ucpu_pkg.sv
source/control_decode.sv
source/alu.sv
source/bus_arbiter.sv
source/program_counter.sv
source/reg_file.sv
source/ram.sv
source/ucpu_top.sv
tb/ucpu_checker.sv
tb/tb_ucpu.sv
